//--- Makefile
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -f esc_link_top.f --top-module esc_link_tb -Mdir build

run: build
	-./build/Vesc_link_tb > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Checks failed" $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	verilator --lint-only -Wall --top-module esc_link_top hw/esc_pkg.sv hw/diff_decode.sv \
		hw/esc_sender.sv hw/esc_receiver.sv hw/esc_link_top.sv

clean:
	rm -rf build $(LOG)

.PHONY: all build run lint clean

//--- esc_link_top.f
hw/esc_pkg.sv
hw/diff_decode.sv
hw/esc_sender.sv
hw/esc_receiver.sv
hw/esc_link_top.sv
test/clk_rst_gen.sv
test/esc_link_tb.sv

//--- hw/diff_decode.sv
`timescale 1ns/1ns

module diff_decode (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  esc_pkg::esc_pair_t pair_i,
	output logic               level_o,
	output logic               sigint_o
);

	logic level_q;

	// ##################################################################
	// decode

	// both wires at the same level means the pair has been tampered with
	// or a wire is stuck
	assign sigint_o = (pair_i.p == pair_i.n);

	// while the pair is broken the last good level is held, so that a
	// glitch on one wire does not reach the logic behind the decoder
	always_comb begin
		if (sigint_o) begin
			level_o = level_q;
		end else begin
			level_o = pair_i.p;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			level_q <= 1'b0;
		end else begin
			level_q <= level_o;
		end
	end

	// ##################################################################
	// assertions

	// a broken pair must never move the decoded level
	a_level_held_on_sigint: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		sigint_o |-> (level_o == $past(level_o))
	);

endmodule

//--- hw/esc_link_top.sv
`timescale 1ns/1ns

module esc_link_top (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               ping_en_i,
	input  logic               esc_en_i,
	input  esc_pkg::esc_pair_t esc_rx_i,
	output logic               ping_ok_o,
	output logic               integ_fail_o,
	output logic               esc_o,
	output esc_pkg::esc_pair_t esc_rx_o
);
	import esc_pkg::*;

	esc_pair_t esc_tx;

	esc_sender esc_sender_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.ping_en_i    (ping_en_i),
		.esc_en_i     (esc_en_i),
		.esc_rx_i     (esc_rx_i),
		.esc_tx_o     (esc_tx),
		.ping_ok_o    (ping_ok_o),
		.integ_fail_o (integ_fail_o)
	);

	// the response pair leaves through esc_rx_o and returns on esc_rx_i,
	// as it would between two blocks of a chip
	esc_receiver esc_receiver_i (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.esc_tx_i (esc_tx),
		.esc_rx_o (esc_rx_o),
		.esc_o    (esc_o)
	);

endmodule

//--- hw/esc_pkg.sv
package esc_pkg;

	// ##################################################################
	// a differential wire pair is valid only while p and n differ
	typedef struct packed {
		logic p;
		logic n;
	} esc_pair_t;

	// ##################################################################
	// the check states of the sender FSM name the response level expected next
	typedef enum logic [2:0] {
		tx_idle          = 3'd0,
		tx_check_esc_lo  = 3'd1,
		tx_check_esc_hi  = 3'd2,
		tx_check_ping_0  = 3'd3,
		tx_check_ping_1  = 3'd4,
		tx_check_ping_2  = 3'd5,
		tx_check_ping_3  = 3'd6
	} esc_sender_state_e;

	// each state of the receiver FSM fixes the level driven on the response pair
	typedef enum logic [2:0] {
		rx_idle        = 3'd0,
		rx_ping_resp_0 = 3'd1,
		rx_ping_resp_1 = 3'd2,
		rx_ping_resp_2 = 3'd3,
		rx_ping_resp_3 = 3'd4,
		rx_esc_lo      = 3'd5,
		rx_esc_hi      = 3'd6
	} esc_receiver_state_e;

endpackage

//--- hw/esc_receiver.sv
`timescale 1ns/1ns

module esc_receiver (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  esc_pkg::esc_pair_t esc_tx_i,
	output esc_pkg::esc_pair_t esc_rx_o,
	output logic               esc_o
);
	import esc_pkg::*;

	logic                esc_level;
	logic                sigint;
	logic                resp;
	esc_receiver_state_e state_d;
	esc_receiver_state_e state_q;

	diff_decode diff_decode_i (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.pair_i   (esc_tx_i),
		.level_o  (esc_level),
		.sigint_o (sigint)
	);

	// ##################################################################
	// response FSM

	// the answer alternates high, low, high, low; a level that is still
	// high in a ping state turns into an escalation of the opposite phase
	always_comb begin
		state_d = state_q;
		resp    = 1'b0;
		esc_o   = 1'b0;
		case (state_q)
			rx_idle: begin
				if (esc_level) begin
					state_d = rx_ping_resp_0;
				end
			end
			rx_ping_resp_0: begin
				resp    = 1'b1;
				state_d = rx_ping_resp_1;
				// still high after the first cycle, so this is no ping
				if (esc_level) begin
					state_d = rx_esc_lo;
					esc_o   = 1'b1;
				end
			end
			rx_ping_resp_1: begin
				state_d = esc_level ? rx_esc_hi : rx_ping_resp_2;
			end
			rx_ping_resp_2: begin
				resp    = 1'b1;
				state_d = esc_level ? rx_esc_lo : rx_ping_resp_3;
			end
			rx_ping_resp_3: begin
				state_d = esc_level ? rx_esc_hi : rx_idle;
			end
			rx_esc_lo: begin
				esc_o   = 1'b1;
				state_d = esc_level ? rx_esc_hi : rx_idle;
			end
			rx_esc_hi: begin
				resp    = 1'b1;
				esc_o   = 1'b1;
				state_d = esc_level ? rx_esc_lo : rx_idle;
			end
			default: state_d = rx_idle;
		endcase
		if (sigint) begin
			state_d = rx_idle;
		end
	end

	// a broken forward pair is mirrored as a broken response, which the
	// sender flags on its own side
	always_comb begin
		esc_rx_o.p = resp;
		esc_rx_o.n = sigint ? resp : ~resp;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= rx_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// ##################################################################
	// assertions

	a_rx_valid_on_valid_tx: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		(esc_tx_i.p != esc_tx_i.n) |-> (esc_rx_o.p != esc_rx_o.n)
	);

endmodule

//--- hw/esc_sender.sv
`timescale 1ns/1ns

module esc_sender (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               ping_en_i,
	input  logic               esc_en_i,
	input  esc_pkg::esc_pair_t esc_rx_i,
	output esc_pkg::esc_pair_t esc_tx_o,
	output logic               ping_ok_o,
	output logic               integ_fail_o
);
	import esc_pkg::*;

	logic              resp;
	logic              sigint;
	logic              esc_level;
	logic              ping_en_q;
	logic              esc_en_q;
	logic              esc_en_q1;
	esc_sender_state_e state_d;
	esc_sender_state_e state_q;

	diff_decode diff_decode_i (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.pair_i   (esc_rx_i),
		.level_o  (resp),
		.sigint_o (sigint)
	);

	// ##################################################################
	// forward pair

	// escalation is held one cycle past the request so the receiver sees
	// a level of at least two cycles, a ping is a single-cycle pulse
	assign esc_level  = esc_en_i | esc_en_q | (ping_en_i & ~ping_en_q);
	assign esc_tx_o.p = esc_level;
	assign esc_tx_o.n = ~esc_level;

	// ##################################################################
	// response check

	always_comb begin
		state_d      = state_q;
		ping_ok_o    = 1'b0;
		integ_fail_o = sigint;
		case (state_q)
			tx_idle: begin
				if (esc_en_i) begin
					state_d = tx_check_esc_hi;
				end else if (ping_en_i && !ping_en_q) begin
					state_d = tx_check_ping_0;
				end
				// the receiver has nothing to answer here
				if (resp) begin
					integ_fail_o = 1'b1;
				end
			end
			tx_check_esc_lo: begin
				state_d = tx_check_esc_hi;
				if (!esc_level || resp) begin
					state_d      = tx_idle;
					integ_fail_o = sigint | resp;
				end
			end
			tx_check_esc_hi: begin
				state_d = tx_check_esc_lo;
				if (!esc_level || !resp) begin
					state_d      = tx_idle;
					integ_fail_o = sigint | ~resp;
				end
			end
			// an escalation takes over the check in the phase the receiver is in
			tx_check_ping_0: begin
				state_d = tx_check_ping_1;
				if (esc_en_i) begin
					state_d = tx_check_esc_lo;
				end else if (!resp) begin
					state_d      = tx_idle;
					integ_fail_o = 1'b1;
				end
			end
			tx_check_ping_1: begin
				state_d = tx_check_ping_2;
				if (esc_en_i) begin
					state_d = tx_check_esc_hi;
				end else if (resp) begin
					state_d      = tx_idle;
					integ_fail_o = 1'b1;
				end
			end
			tx_check_ping_2: begin
				state_d = tx_check_ping_3;
				if (esc_en_i) begin
					state_d = tx_check_esc_lo;
				end else if (!resp) begin
					state_d      = tx_idle;
					integ_fail_o = 1'b1;
				end
			end
			tx_check_ping_3: begin
				state_d = tx_idle;
				if (esc_en_i) begin
					state_d = tx_check_esc_hi;
				end else if (resp) begin
					integ_fail_o = 1'b1;
				end else begin
					ping_ok_o = ping_en_i;
				end
			end
			default: state_d = tx_idle;
		endcase

		// an active or recent escalation already proves the path is alive
		if ((esc_en_i || esc_en_q || esc_en_q1) && ping_en_i) begin
			ping_ok_o = 1'b1;
		end
		if (sigint) begin
			state_d = tx_idle;
		end
		if (integ_fail_o) begin
			ping_ok_o = 1'b0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q   <= tx_idle;
			ping_en_q <= 1'b0;
			esc_en_q  <= 1'b0;
			esc_en_q1 <= 1'b0;
		end else begin
			state_q   <= state_d;
			ping_en_q <= ping_en_i;
			esc_en_q  <= esc_en_i;
			esc_en_q1 <= esc_en_q;
		end
	end

	// ##################################################################
	// assertions

	a_tx_complementary: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		esc_tx_o.p != esc_tx_o.n
	);

	a_ok_excludes_fail: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		!(ping_ok_o && integ_fail_o)
	);

endmodule

//--- test/clk_rst_gen.sv
`timescale 1ns/1ns

module clk_rst_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 4
) (
	output logic clk_o,
	output logic rst_no
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(period_ns / 2);
			clk_o = ~clk_o;
		end
	end

	// reset is released at the drive delay after an edge, like every other input
	initial begin
		rst_no = 1'b0;
		repeat (reset_cycles) @(posedge clk_o);
		#2;
		rst_no = 1'b1;
	end

endmodule

//--- test/esc_link_tb.sv
`timescale 1ns/1ns

module esc_link_tb;
	import esc_pkg::*;

	localparam int clk_period  = 20;
	localparam int n_pings     = 8;
	localparam int n_escs      = 8;
	localparam int n_mixed     = 6;
	localparam int n_faults    = 3;
	localparam int test_cycles = 40 + n_pings * 20 + n_escs * 35 + n_mixed * 30
		+ n_faults * 45;
	localparam int max_cycles  = 4096;

	typedef enum logic [1:0] {
		fault_none,
		fault_low,
		fault_equal,
		fault_high
	} fault_e;

	typedef struct packed {
		logic ping_ok;
		logic esc;
		logic integ_fail;
	} status_t;

	logic      clk;
	logic      rst_n;
	logic      ping_en;
	logic      esc_en;
	esc_pair_t esc_rx;
	logic      ping_ok;
	logic      integ_fail;
	logic      esc;
	esc_pair_t esc_rx_o;
	fault_e    fault_mode;
	logic      equal_level;
	int        cyc;
	logic      ping_hist [max_cycles];
	logic      esc_hist [max_cycles];
	logic      fail_hist [max_cycles];
	fault_e    fault_hist [max_cycles];

	clk_rst_gen #(
		.period_ns    (clk_period),
		.reset_cycles (4)
	) clk_rst_gen_i (
		.clk_o  (clk),
		.rst_no (rst_n)
	);

	esc_link_top esc_link_top_i (
		.clk_i        (clk),
		.rst_ni       (rst_n),
		.ping_en_i    (ping_en),
		.esc_en_i     (esc_en),
		.esc_rx_i     (esc_rx),
		.ping_ok_o    (ping_ok),
		.integ_fail_o (integ_fail),
		.esc_o        (esc),
		.esc_rx_o     (esc_rx_o)
	);

	// the response pair normally comes straight back, a fault replaces it
	always_comb begin
		case (fault_mode)
			fault_low:   esc_rx = '{p: 1'b0, n: 1'b1};
			fault_equal: esc_rx = '{p: equal_level, n: equal_level};
			fault_high:  esc_rx = '{p: 1'b1, n: 1'b0};
			default:     esc_rx = esc_rx_o;
		endcase
	end

	// ####################################################################
	// reference model

	function automatic logic ping_at(int t);
		if (t < 0) begin
			return 1'b0;
		end
		return ping_hist[t];
	endfunction

	function automatic logic esc_at(int t);
		if (t < 0) begin
			return 1'b0;
		end
		return esc_hist[t];
	endfunction

	// a ping edge is answered 1, 0, 1, 0 in the four cycles after it;
	// once a check has failed the sender no longer waits for the rest
	function automatic status_t expect_status(int t);
		status_t e;
		int      k;
		int      d;
		int      u;
		logic    alive;
		logic    resp_hi;
		logic    esc_recent;
		k = 0;
		for (d = 4; d >= 1; d--) begin
			if (ping_at(t - d) && !ping_at(t - d - 1)) begin
				k = d;
			end
		end
		alive = (k != 0);
		for (u = t - k + 1; u < t; u++) begin
			if (fail_hist[u]) begin
				alive = 1'b0;
			end
		end
		resp_hi    = alive && (k == 1 || k == 3);
		esc_recent = esc_at(t) | esc_at(t - 1) | esc_at(t - 2);
		e.esc      = esc_at(t - 1) | esc_at(t - 2);
		case (fault_hist[t])
			fault_low:   e.integ_fail = resp_hi;
			fault_equal: e.integ_fail = 1'b1;
			fault_high:  e.integ_fail = !resp_hi;
			default:     e.integ_fail = 1'b0;
		endcase
		e.ping_ok = ping_at(t) && ((k == 4 && alive) || esc_recent) && !e.integ_fail;
		return e;
	endfunction

	task automatic check_val(string name, logic act, logic exp);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%0h, got 0x%0h in cycle %0d", name, exp, act, cyc);
			$display("Checks failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		status_t exp_s;
		if (rst_n) begin
			if (cyc >= max_cycles) begin
				$display("the cycle history is full, the tests ran longer than expected");
				$display("Checks failed");
				$fatal(1, "history overflow");
			end else begin
				ping_hist[cyc]  = ping_en;
				esc_hist[cyc]   = esc_en;
				fault_hist[cyc] = fault_mode;
				exp_s           = expect_status(cyc);
				fail_hist[cyc]  = exp_s.integ_fail;
				check_val("ping_ok_o", ping_ok, exp_s.ping_ok);
				check_val("esc_o", esc, exp_s.esc);
				check_val("integ_fail_o", integ_fail, exp_s.integ_fail);
				check_val("esc_rx_o.p ^ esc_rx_o.n", esc_rx_o.p ^ esc_rx_o.n, 1'b1);
				cyc++;
			end
		end
	end

	// ####################################################################
	// stimulus

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic idle_cycles(int n);
		repeat (n) next_cycle();
	endtask

	// the request is held until ping_ok_o answers it
	task automatic ping_loopback();
		int waited;
		waited  = 0;
		ping_en = 1'b1;
		@(negedge clk);
		while (!ping_ok) begin
			waited++;
			if (waited > 8) begin
				$display("no ping_ok_o within 8 cycles of a ping request");
				$display("Checks failed");
				$fatal(1, "ping timeout");
			end else begin
				@(negedge clk);
			end
		end
		next_cycle();
		ping_en = 1'b0;
	endtask

	task automatic escalate(int len);
		esc_en = 1'b1;
		idle_cycles(len);
		esc_en = 1'b0;
	endtask

	task automatic ping_with_escalation(int offset, int len);
		ping_en = 1'b1;
		idle_cycles(offset);
		escalate(len);
		idle_cycles(2);
		ping_en = 1'b0;
	endtask

	// the failed request stays up past the whole answer, so a held level
	// must not start another check
	task automatic ping_stuck_low();
		fault_mode = fault_low;
		ping_en    = 1'b1;
		idle_cycles(5);
		ping_en    = 1'b0;
		fault_mode = fault_none;
	endtask

	task automatic force_rx(fault_e mode, int len);
		fault_mode  = mode;
		equal_level = 1'($urandom_range(0, 1));
		idle_cycles(len);
		fault_mode  = fault_none;
	endtask

	initial begin
		ping_en     = 1'b0;
		esc_en      = 1'b0;
		fault_mode  = fault_none;
		equal_level = 1'b0;
		cyc         = 0;
		void'($urandom(59));
		@(posedge rst_n);
		@(negedge clk);
		check_val("esc_rx_o.p", esc_rx_o.p, 1'b0);
		check_val("esc_rx_o.n", esc_rx_o.n, 1'b1);
		idle_cycles(3);
		repeat (n_pings) begin
			ping_loopback();
			idle_cycles($urandom_range(4, 11));
		end
		repeat (n_escs) begin
			escalate($urandom_range(1, 20));
			idle_cycles($urandom_range(4, 11));
		end
		repeat (n_mixed) begin
			ping_with_escalation($urandom_range(2, 4), $urandom_range(1, 10));
			idle_cycles($urandom_range(4, 11));
		end
		repeat (n_faults) begin
			ping_stuck_low();
			idle_cycles($urandom_range(4, 11));
			force_rx(fault_equal, $urandom_range(1, 3));
			idle_cycles($urandom_range(4, 11));
			force_rx(fault_high, $urandom_range(1, 3));
			idle_cycles($urandom_range(4, 11));
		end
		$display("All checks passed");
		$finish;
	end

	initial begin
		#(2 * test_cycles * clk_period);
		$display("watchdog expired before the tests finished");
		$display("Checks failed");
		$fatal(1, "watchdog timeout");
	end

endmodule
